// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the SRAM FIFO testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module sram_fifo_tb \
    -f sram_fifo.f -o sram_fifo_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sram_fifo_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
    exit 0
fi
exit 1

// ==== sim/sram_fifo_tb.sv ====
/* SRAM FIFO testbench */
`timescale 1ns/1ps

module sram_fifo_tb
    import fifo_regs_pkg::*;
();
    localparam int DEPTH   = 64;
    localparam int AF_PCT  = 95;
    localparam int AE_PCT  = 5;
    localparam int AF_INIT = 255 * AF_PCT / 100;
    localparam int AE_INIT = 255 * AE_PCT / 100;
    localparam int TIMEOUT = 4000;  // about twice the summed test lengths

    logic        BUS_CLK, BUS_RST, BUS_RD, BUS_WR, USB_READ, FIFO_EMPTY_IN;
    logic [15:0] BUS_ADD;
    logic [7:0]  BUS_DATA_IN, BUS_DATA_OUT, USB_DATA;
    logic [31:0] FIFO_DATA;
    logic [19:0] SRAM_A;
    logic [15:0] SRAM_DQ_OUT, SRAM_DQ_IN;
    logic        SRAM_DQ_OE, SRAM_WE_B, SRAM_OE_B;
    logic        FIFO_READ_NEXT_OUT, FIFO_NOT_EMPTY, FIFO_FULL, FIFO_NEAR_FULL;
    logic        FIFO_READ_ERROR;

    integer     seed;
    int         errors, passed, failed, cycles, err_mark;
    logic [7:0] ref_q [$];
    logic [7:0] rd_val;
    int         stored, size_d, writes_seen, err_exp, af_thr, ae_thr, size_bytes;
    logic       nf_exp, nf_seen, rst_any;

    sram_fifo #(.DEPTH(DEPTH), .ALMOST_FULL_PCT(AF_PCT), .ALMOST_EMPTY_PCT(AE_PCT)) uut (
        .BUS_CLK(BUS_CLK), .BUS_RST(BUS_RST), .BUS_ADD(BUS_ADD), .BUS_DATA_IN(BUS_DATA_IN),
        .BUS_RD(BUS_RD), .BUS_WR(BUS_WR), .BUS_DATA_OUT(BUS_DATA_OUT), .SRAM_A(SRAM_A),
        .SRAM_DQ_OUT(SRAM_DQ_OUT), .SRAM_DQ_IN(SRAM_DQ_IN), .SRAM_DQ_OE(SRAM_DQ_OE),
        .SRAM_WE_B(SRAM_WE_B), .SRAM_OE_B(SRAM_OE_B), .USB_READ(USB_READ),
        .USB_DATA(USB_DATA), .FIFO_READ_NEXT_OUT(FIFO_READ_NEXT_OUT),
        .FIFO_EMPTY_IN(FIFO_EMPTY_IN), .FIFO_DATA(FIFO_DATA),
        .FIFO_NOT_EMPTY(FIFO_NOT_EMPTY), .FIFO_FULL(FIFO_FULL),
        .FIFO_NEAR_FULL(FIFO_NEAR_FULL), .FIFO_READ_ERROR(FIFO_READ_ERROR));

    sram_model #(.AW(6)) i_sram (
        .BUS_CLK(BUS_CLK), .a(SRAM_A[5:0]), .dq_out(SRAM_DQ_OUT), .dq_oe(SRAM_DQ_OE),
        .we_b(SRAM_WE_B), .oe_b(SRAM_OE_B), .dq_in(SRAM_DQ_IN));

    always #2 BUS_CLK = ~BUS_CLK;

    assign rst_any = BUS_RST || (BUS_WR && BUS_ADD == 16'(addr_ctrl_rst));

    // reference model of occupancy, flags and error count, from the SRAM strobes
    always @(posedge BUS_CLK) begin
        if (rst_any) begin
            stored <= 0;
            size_d <= 0;
            writes_seen <= 0;
            err_exp <= 0;
            nf_exp <= 1'b0;
            nf_seen <= 1'b0;
            af_thr <= AF_INIT;
            ae_thr <= AE_INIT;
        end else begin
            stored <= stored + int'(!SRAM_WE_B) - int'(!SRAM_OE_B);
            size_d <= stored;   // size register lags one cycle
            writes_seen <= writes_seen + int'(!SRAM_WE_B);
            if (size_d * 256 >= (af_thr + 1) * DEPTH)
                nf_exp <= 1'b1;
            else if (size_d * 256 <= (ae_thr + 1) * DEPTH || stored == 0)
                nf_exp <= 1'b0;
            if (USB_READ && stored == 0 && err_exp != 255)
                err_exp <= err_exp + 1;
            if (FIFO_NEAR_FULL)
                nf_seen <= 1'b1;
            if (BUS_WR && BUS_ADD == 16'(addr_almost_full))
                af_thr <= int'(BUS_DATA_IN);
            if (BUS_WR && BUS_ADD == 16'(addr_almost_empty))
                ae_thr <= int'(BUS_DATA_IN);
        end
    end

    a_not_empty: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        FIFO_NOT_EMPTY == (stored != 0)) else begin
        errors++;
        $display("ERROR %0t: FIFO_NOT_EMPTY %b with %0d stored", $time, FIFO_NOT_EMPTY, stored);
    end
    a_full: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        FIFO_FULL == (stored == DEPTH - 1)) else begin
        errors++;
        $display("ERROR %0t: FIFO_FULL %b with %0d stored", $time, FIFO_FULL, stored);
    end
    a_near_full: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        FIFO_NEAR_FULL == nf_exp) else begin
        errors++;
        $display("ERROR %0t: FIFO_NEAR_FULL %b, expected %b", $time, FIFO_NEAR_FULL, nf_exp);
    end
    a_read_err: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        FIFO_READ_ERROR == (err_exp != 0)) else begin
        errors++;
        $display("ERROR %0t: FIFO_READ_ERROR %b, count %0d", $time, FIFO_READ_ERROR, err_exp);
    end

    always @(posedge BUS_CLK) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic check_val(input int got, input int exp, input string what);
        assert (got == exp) else begin
            errors++;
            $display("ERROR %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic bus_write(input reg_addr_e a, input logic [7:0] d);
        @(negedge BUS_CLK);
        BUS_ADD = 16'(a);
        BUS_DATA_IN = d;
        BUS_WR = 1'b1;
        @(negedge BUS_CLK);
        BUS_WR = 1'b0;
    endtask

    task automatic bus_read(input reg_addr_e a, output logic [7:0] d);
        @(negedge BUS_CLK);
        BUS_ADD = 16'(a);
        BUS_RD = 1'b1;
        @(negedge BUS_CLK);
        BUS_RD = 1'b0;
        d = BUS_DATA_OUT;   // registered one cycle after the read
    endtask

    task automatic read_size(output int bytes);
        logic [7:0] lo, mid, hi;
        bus_read(addr_size_lo, lo);     // latches mid and hi
        bus_read(addr_size_mid, mid);
        bus_read(addr_size_hi, hi);
        bytes = {hi, mid, lo};
    endtask

    task automatic push_word();
        logic [31:0] w;
        w = $random(seed);
        @(negedge BUS_CLK);
        FIFO_DATA = w;
        FIFO_EMPTY_IN = 1'b0;
        while (!FIFO_READ_NEXT_OUT)
            @(negedge BUS_CLK);
        @(negedge BUS_CLK);
        FIFO_EMPTY_IN = 1'b1;
        for (int i = 0; i < 4; i++)
            ref_q.push_back(w[8*i +: 8]);   // low byte first
    endtask

    task automatic read_byte_check();
        logic [7:0] exp;
        @(negedge BUS_CLK);
        exp = ref_q.pop_front();
        check_val(int'(USB_DATA), int'(exp), "USB byte");
        USB_READ = 1'b1;
        @(negedge BUS_CLK);
        USB_READ = 1'b0;
        repeat (3) @(negedge BUS_CLK);  // strobe spacing
    endtask

    task automatic usb_strobe();
        @(negedge BUS_CLK);
        USB_READ = 1'b1;
        @(negedge BUS_CLK);
        USB_READ = 1'b0;
        repeat (3) @(negedge BUS_CLK);
    endtask

    task automatic end_test(input string name);
        if (errors == err_mark) begin
            passed++;
            $display("test %s: pass", name);
        end else begin
            failed++;
            $display("test %s: fail", name);
        end
        err_mark = errors;
    endtask

    initial begin
        seed = 32'h3548_2c1f;
        BUS_CLK = 1'b0;
        BUS_RST = 1'b1;
        BUS_ADD = '0;
        BUS_DATA_IN = '0;
        BUS_RD = 1'b0;
        BUS_WR = 1'b0;
        USB_READ = 1'b0;
        FIFO_EMPTY_IN = 1'b1;
        FIFO_DATA = '0;
        repeat (16) @(posedge BUS_CLK);
        @(negedge BUS_CLK);
        BUS_RST = 1'b0;

        bus_read(addr_ctrl_rst, rd_val);
        check_val(int'(rd_val), 2, "version");
        bus_read(addr_almost_full, rd_val);
        check_val(int'(rd_val), AF_INIT, "almost-full default");
        bus_read(addr_almost_empty, rd_val);
        check_val(int'(rd_val), AE_INIT, "almost-empty default");
        bus_write(addr_almost_full, 8'h5a);
        bus_write(addr_almost_empty, 8'h21);
        bus_read(addr_almost_full, rd_val);
        check_val(int'(rd_val), 'h5a, "almost-full write-back");
        bus_read(addr_almost_empty, rd_val);
        check_val(int'(rd_val), 'h21, "almost-empty write-back");
        bus_write(addr_ctrl_rst, 8'h00);    // restore default thresholds
        end_test("registers");

        repeat (20) push_word();
        repeat (80) read_byte_check();
        end_test("data order");

        bus_write(addr_ctrl_rst, 8'h00);
        ref_q.delete();
        repeat (5) push_word();
        while (writes_seen != 10)
            @(negedge BUS_CLK);
        repeat (3) @(negedge BUS_CLK);
        read_size(size_bytes);
        // reader prefetch holds one half-word outside the ring
        check_val(size_bytes, 2 * (2 * 5 - 1), "size in bytes");
        end_test("size");

        bus_write(addr_ctrl_rst, 8'h00);
        ref_q.delete();
        repeat (5) usb_strobe();
        bus_read(addr_read_err, rd_val);
        check_val(int'(rd_val), 5, "read error count");
        check_val(int'(FIFO_READ_ERROR), 1, "FIFO_READ_ERROR");
        repeat (2) push_word();     // stored data for the reset to clear
        check_val(int'(FIFO_NOT_EMPTY), 1, "FIFO_NOT_EMPTY before soft reset");
        bus_write(addr_ctrl_rst, 8'h00);
        ref_q.delete();
        @(negedge BUS_CLK);
        bus_read(addr_read_err, rd_val);
        check_val(int'(rd_val), 0, "count after soft reset");
        check_val(int'(FIFO_READ_ERROR), 0, "FIFO_READ_ERROR after soft reset");
        check_val(int'(FIFO_NOT_EMPTY), 0, "FIFO_NOT_EMPTY after soft reset");
        check_val(int'(FIFO_FULL), 0, "FIFO_FULL after soft reset");
        check_val(int'(FIFO_NEAR_FULL), 0, "FIFO_NEAR_FULL after soft reset");
        check_val(int'(FIFO_READ_NEXT_OUT), 1, "FIFO_READ_NEXT_OUT after soft reset");
        check_val(int'(SRAM_WE_B && SRAM_OE_B), 1, "SRAM strobes idle");
        end_test("read errors");

        while (FIFO_READ_NEXT_OUT && ref_q.size() < 320)
            push_word();
        repeat (4) @(negedge BUS_CLK);
        check_val(int'(FIFO_FULL), 1, "FIFO_FULL when filled");
        check_val(int'(FIFO_READ_NEXT_OUT), 0, "FIFO_READ_NEXT_OUT when filled");
        read_size(size_bytes);
        check_val(size_bytes, 2 * (DEPTH - 1), "size when full");
        while (ref_q.size() > 0)
            read_byte_check();
        repeat (4) @(negedge BUS_CLK);
        check_val(int'(nf_seen), 1, "near-full seen while filled");
        check_val(int'(FIFO_NEAR_FULL), 0, "FIFO_NEAR_FULL after drain");
        end_test("full and hysteresis");

        $display("tests passed %0d, failed %0d, check errors %0d", passed, failed, errors);
        if (failed == 0 && errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end
endmodule

// ==== sim/sram_model.sv ====
/* behavioral SRAM */
`timescale 1ns/1ps

module sram_model #(
    parameter int AW = 6
) (
    input  logic          BUS_CLK,
    input  logic [AW-1:0] a,
    input  logic [15:0]   dq_out,
    input  logic          dq_oe,
    input  logic          we_b,
    input  logic          oe_b,
    output logic [15:0]   dq_in
);
    logic [15:0] mem [0:(1<<AW)-1];

    always @(posedge BUS_CLK) begin
        if (!we_b && dq_oe)
            mem[a] <= dq_out;   // clocked write
    end

    assign dq_in = oe_b ? 16'h0000 : mem[a];   // async read
endmodule

// ==== sram_fifo.f ====
src/fifo_regs_pkg.sv
src/sram_types_pkg.sv
src/fifo_ifs.sv
src/bus_regs.sv
src/word_stager.sv
src/sram_ring_ctrl.sv
src/usb_byte_reader.sv
src/sram_fifo.sv
sim/sram_model.sv
sim/sram_fifo_tb.sv

// ==== src/bus_regs.sv ====
/* FIFO bus registers and flags */
`timescale 1ns/1ps

module bus_regs
    import fifo_regs_pkg::*;
#(
    parameter int unsigned DEPTH            = 1048576,
    parameter int unsigned ALMOST_FULL_PCT  = 95,
    parameter int unsigned ALMOST_EMPTY_PCT = 5
) (
    input  logic        BUS_CLK,
    input  logic        RST,
    input  logic [15:0] bus_add,
    input  logic [7:0]  bus_data_in,
    input  logic        bus_wr,
    input  logic        bus_rd,
    input  logic [20:0] size_halfwords,
    input  logic        ring_empty,
    input  logic        usb_read,
    output logic [7:0]  bus_data_out,
    output logic        soft_rst,
    output logic        near_full,
    output logic        read_error
);
    localparam logic [7:0] AF_INIT = 8'(255 * ALMOST_FULL_PCT / 100);
    localparam logic [7:0] AE_INIT = 8'(255 * ALMOST_EMPTY_PCT / 100);

    reg_addr_e   addr;
    logic        addr_hit;
    logic [7:0]  almost_full;
    logic [7:0]  almost_empty;
    logic [7:0]  err_cnt;
    logic [21:0] size_byte;
    logic [21:0] size_byte_buf;     // snapshot for mid/hi reads
    logic [28:0] af_prod;
    logic [28:0] ae_prod;

    assign addr = reg_addr_e'(bus_add[2:0]);
    assign addr_hit = bus_add < 16'(REG_COUNT);
    assign soft_rst = bus_wr && addr_hit && addr == addr_ctrl_rst;
    assign size_byte = {size_halfwords, 1'b0};
    assign read_error = err_cnt != 8'd0;

    // thresholds in 1/256 steps of the ring depth
    assign af_prod = (29'(almost_full) + 29'd1) * 29'(DEPTH);
    assign ae_prod = (29'(almost_empty) + 29'd1) * 29'(DEPTH);

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            almost_full <= AF_INIT;
            almost_empty <= AE_INIT;
        end else if (bus_wr && addr_hit && addr == addr_almost_full) begin
            almost_full <= bus_data_in;
        end else if (bus_wr && addr_hit && addr == addr_almost_empty) begin
            almost_empty <= bus_data_in;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (bus_rd) begin
            if (!addr_hit) begin
                bus_data_out <= 8'd0;
            end else begin
                case (addr)
                    addr_ctrl_rst:     bus_data_out <= FIFO_VERSION;
                    addr_almost_full:  bus_data_out <= almost_full;
                    addr_almost_empty: bus_data_out <= almost_empty;
                    addr_read_err:     bus_data_out <= err_cnt;
                    addr_size_lo:      bus_data_out <= size_byte[7:0];  // live value
                    addr_size_mid:     bus_data_out <= size_byte_buf[15:8];
                    addr_size_hi:      bus_data_out <= {2'b00, size_byte_buf[21:16]};
                    default:           bus_data_out <= 8'd0;
                endcase
            end
        end
        if (bus_rd && addr_hit && addr == addr_size_lo)
            size_byte_buf <= size_byte;
    end

    // reads attempted on an empty ring, saturating
    always_ff @(posedge BUS_CLK) begin
        if (RST)
            err_cnt <= 8'd0;
        else if (usb_read && ring_empty && err_cnt != 8'hff)
            err_cnt <= err_cnt + 8'd1;
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST)
            near_full <= 1'b0;
        else if ({size_halfwords, 8'd0} >= af_prod)
            near_full <= 1'b1;
        else if ({size_halfwords, 8'd0} <= ae_prod || ring_empty)
            near_full <= 1'b0;  // hysteresis low side
    end

    // soft reset comes only from a bus write and clears the status next cycle
    a_soft_rst: assert property (@(posedge BUS_CLK)
        soft_rst |-> bus_wr ##1 (err_cnt == 8'd0 && !near_full));

endmodule

// ==== src/fifo_ifs.sv ====
/* ring write and read channels */
`timescale 1ns/1ps

// producer side, one half-word per ack
interface ring_wr_if import sram_types_pkg::*; ();
    logic       wr_req;
    sram_word_t wr_data;
    logic       wr_ack;     // half-word written this cycle
    logic       wr_full;

    modport producer (output wr_req, output wr_data, input wr_ack, input wr_full);
    modport buffer (input wr_req, input wr_data, output wr_ack, output wr_full);
endinterface

// consumer side, data valid during the fetch cycle
interface ring_rd_if import sram_types_pkg::*; ();
    logic       rd_fetch;
    sram_word_t rd_data;
    logic       rd_empty;

    modport consumer (
        output rd_fetch,
        input  rd_data,
        input  rd_empty
    );
    modport buffer (
        input  rd_fetch,
        output rd_data,
        output rd_empty
    );
endinterface

// ==== src/fifo_regs_pkg.sv ====
/* FIFO register map */

package fifo_regs_pkg;

    // bus register addresses
    typedef enum logic [2:0] {
        addr_ctrl_rst     = 3'd0,   // version on read, soft reset on write
        addr_almost_full  = 3'd1,
        addr_almost_empty = 3'd2,
        addr_read_err     = 3'd3,
        addr_size_lo      = 3'd4,   // read latches full byte size
        addr_size_mid     = 3'd5,
        addr_size_hi      = 3'd6,
        addr_reserved     = 3'd7    // reads zero
    } reg_addr_e;

    localparam logic [7:0] FIFO_VERSION = 8'd2;

    // decoded address window
    localparam int REG_COUNT = 8;

endpackage

// ==== src/sram_fifo.sv ====
/* SRAM backed FIFO top */
`timescale 1ns/1ps

module sram_fifo
    import sram_types_pkg::*;
#(
    parameter int unsigned DEPTH            = 1048576,
    parameter int unsigned ALMOST_FULL_PCT  = 95,
    parameter int unsigned ALMOST_EMPTY_PCT = 5,
    parameter int unsigned IN_DEPTH         = 16
) (
    input  logic               BUS_CLK,
    input  logic               BUS_RST,
    input  logic [15:0]        BUS_ADD,
    input  logic [7:0]         BUS_DATA_IN,
    input  logic               BUS_RD,
    input  logic               BUS_WR,
    output logic [7:0]         BUS_DATA_OUT,
    output logic [SRAM_AW-1:0] SRAM_A,
    output logic [SRAM_DW-1:0] SRAM_DQ_OUT,
    input  logic [SRAM_DW-1:0] SRAM_DQ_IN,
    output logic               SRAM_DQ_OE,
    output logic               SRAM_WE_B,
    output logic               SRAM_OE_B,
    input  logic               USB_READ,
    output logic [7:0]         USB_DATA,
    output logic               FIFO_READ_NEXT_OUT,
    input  logic               FIFO_EMPTY_IN,
    input  logic [31:0]        FIFO_DATA,
    output logic               FIFO_NOT_EMPTY,
    output logic               FIFO_FULL,
    output logic               FIFO_NEAR_FULL,
    output logic               FIFO_READ_ERROR
);
    logic             rst, soft_rst;
    logic             ring_empty, ring_full;
    logic [SRAM_AW:0] size_halfwords;

    ring_wr_if wr_bus ();
    ring_rd_if rd_bus ();

    assign rst = BUS_RST | soft_rst;    // bus write to address 0 also resets
    assign FIFO_NOT_EMPTY = !ring_empty;
    assign FIFO_FULL = ring_full;

    bus_regs #(.DEPTH(DEPTH), .ALMOST_FULL_PCT(ALMOST_FULL_PCT),
               .ALMOST_EMPTY_PCT(ALMOST_EMPTY_PCT)) i_regs (
        .BUS_CLK(BUS_CLK), .RST(rst), .bus_add(BUS_ADD), .bus_data_in(BUS_DATA_IN),
        .bus_wr(BUS_WR), .bus_rd(BUS_RD), .size_halfwords(size_halfwords),
        .ring_empty(ring_empty), .usb_read(USB_READ), .bus_data_out(BUS_DATA_OUT),
        .soft_rst(soft_rst), .near_full(FIFO_NEAR_FULL), .read_error(FIFO_READ_ERROR));

    word_stager #(.IN_DEPTH(IN_DEPTH)) i_stager (
        .BUS_CLK(BUS_CLK), .RST(rst), .in_data(FIFO_DATA), .in_empty(FIFO_EMPTY_IN),
        .in_take(FIFO_READ_NEXT_OUT), .wr(wr_bus.producer));

    sram_ring_ctrl #(.DEPTH(DEPTH)) i_ring (
        .BUS_CLK(BUS_CLK), .RST(rst), .sram_dq_in(SRAM_DQ_IN), .sram_a(SRAM_A),
        .sram_dq_out(SRAM_DQ_OUT), .sram_dq_oe(SRAM_DQ_OE), .sram_we_b(SRAM_WE_B),
        .sram_oe_b(SRAM_OE_B), .size_halfwords(size_halfwords), .ring_empty(ring_empty),
        .ring_full(ring_full), .wr(wr_bus.buffer), .rd(rd_bus.buffer));

    usb_byte_reader i_reader (
        .BUS_CLK(BUS_CLK), .RST(rst), .usb_read(USB_READ), .usb_data(USB_DATA),
        .rd(rd_bus.consumer));

endmodule

// ==== src/sram_ring_ctrl.sv ====
/* SRAM ring controller */
`timescale 1ns/1ps

module sram_ring_ctrl
    import sram_types_pkg::*;
#(
    parameter int unsigned DEPTH = 1048576
) (
    input  logic             BUS_CLK,
    input  logic             RST,
    input  sram_word_t       sram_dq_in,
    output sram_addr_t       sram_a,
    output sram_word_t       sram_dq_out,
    output logic             sram_dq_oe,
    output logic             sram_we_b,
    output logic             sram_oe_b,
    output logic [SRAM_AW:0] size_halfwords,
    output logic             ring_empty,
    output logic             ring_full,
    ring_wr_if.buffer        wr,
    ring_rd_if.buffer        rd
);
    localparam sram_addr_t       LAST    = sram_addr_t'(DEPTH - 1);
    localparam logic [SRAM_AW:0] DEPTH_W = DEPTH[SRAM_AW:0];

    sram_addr_t       wr_ptr, rd_ptr;
    sram_addr_t       wr_nxt, rd_nxt;
    logic [SRAM_AW:0] occupancy;

    assign wr_nxt = (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
    assign rd_nxt = (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
    assign ring_empty = wr_ptr == rd_ptr;
    assign ring_full = wr_nxt == rd_ptr;   // one slot kept free

    // reads win the port
    assign wr.wr_ack = wr.wr_req && !ring_full && !rd.rd_fetch;
    assign wr.wr_full = ring_full;
    assign rd.rd_empty = ring_empty;
    assign rd.rd_data = sram_dq_in;         // async read, same cycle

    // pin drive
    assign sram_a = rd.rd_fetch ? rd_ptr : wr_ptr;
    assign sram_dq_out = wr.wr_data;
    assign sram_dq_oe = wr.wr_ack;
    assign sram_we_b = !wr.wr_ack;
    assign sram_oe_b = !rd.rd_fetch;

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr.wr_ack)
                wr_ptr <= wr_nxt;
            if (rd.rd_fetch)
                rd_ptr <= rd_nxt;
        end
    end

    always_comb begin
        if (wr_ptr >= rd_ptr)
            occupancy = {1'b0, wr_ptr} - {1'b0, rd_ptr};
        else
            occupancy = {1'b0, wr_ptr} + DEPTH_W - {1'b0, rd_ptr};   // wrapped
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST)
            size_halfwords <= '0;
        else
            size_halfwords <= occupancy;
    end

    a_port_excl: assert property (@(posedge BUS_CLK) disable iff (RST)
        !(wr.wr_ack && rd.rd_fetch));
    a_ptr_range: assert property (@(posedge BUS_CLK) disable iff (RST)
        wr_ptr < DEPTH && rd_ptr < DEPTH);

endmodule

// ==== src/sram_types_pkg.sv ====
/* SRAM port types */

package sram_types_pkg;

    localparam int SRAM_AW = 20;    // half-word address bits
    localparam int SRAM_DW = 16;

    typedef logic [SRAM_AW-1:0] sram_addr_t;
    typedef logic [SRAM_DW-1:0] sram_word_t;

    // consumer prefetch states
    typedef enum logic [1:0] {
        rd_try,     // waiting for stored data
        rd_fetch,   // SRAM read cycle
        rd_hold     // half-word held for USB
    } rd_state_e;

endpackage

// ==== src/usb_byte_reader.sv ====
/* USB byte reader */
`timescale 1ns/1ps

module usb_byte_reader
    import sram_types_pkg::*;
(
    input  logic        BUS_CLK,
    input  logic        RST,
    input  logic        usb_read,
    output logic [7:0]  usb_data,
    ring_rd_if.consumer rd
);
    rd_state_e  state, state_nxt;
    sram_word_t held;       // prefetched half-word
    logic       hi_sel;     // high byte shown

    always_comb begin
        state_nxt = state;
        case (state)
            rd_try:   if (!rd.rd_empty) state_nxt = rd_fetch;
            rd_fetch: state_nxt = rd_hold;
            rd_hold:  if (usb_read && hi_sel) state_nxt = rd.rd_empty ? rd_try : rd_fetch;
            default:  state_nxt = rd_try;
        endcase
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            state <= rd_try;
            hi_sel <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == rd_fetch)
                hi_sel <= 1'b0;   // new word starts at low byte
            else if (state == rd_hold && usb_read && !hi_sel)
                hi_sel <= 1'b1;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (state == rd_fetch)
            held <= rd.rd_data;
    end

    assign rd.rd_fetch = state == rd_fetch;
    assign usb_data = hi_sel ? held[15:8] : held[7:0];

    a_fetch_nonempty: assert property (@(posedge BUS_CLK) disable iff (RST)
        rd.rd_fetch |-> !rd.rd_empty);

endmodule

// ==== src/word_stager.sv ====
/* input word buffer and splitter */
`timescale 1ns/1ps

module word_stager
    import sram_types_pkg::*;
#(
    parameter int unsigned IN_DEPTH = 16
) (
    input  logic                 BUS_CLK,
    input  logic                 RST,
    input  logic [2*SRAM_DW-1:0] in_data,
    input  logic                 in_empty,
    output logic                 in_take,
    ring_wr_if.producer          wr
);
    localparam int PW = $clog2(IN_DEPTH);
    localparam int CW = $clog2(IN_DEPTH + 1);

    logic [2*SRAM_DW-1:0] mem [IN_DEPTH];
    logic [PW-1:0]        head;         // oldest word
    logic [PW-1:0]        tail;
    logic [CW-1:0]        count;
    logic                 hi_half;      // high half presented next
    logic                 st_full, st_empty, push, pop;

    assign st_full = count == CW'(IN_DEPTH);
    assign st_empty = count == '0;
    assign in_take = !st_full;
    assign push = in_take && !in_empty;
    assign pop = wr.wr_ack && hi_half;  // word done after high half

    assign wr.wr_req = !st_empty;
    assign wr.wr_data = hi_half ? mem[head][2*SRAM_DW-1:SRAM_DW] : mem[head][SRAM_DW-1:0];

    always_ff @(posedge BUS_CLK) begin
        if (push)
            mem[tail] <= in_data;
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            hi_half <= 1'b0;
        end else begin
            if (push)
                tail <= (tail == PW'(IN_DEPTH - 1)) ? '0 : tail + 1'b1;
            if (pop)
                head <= (head == PW'(IN_DEPTH - 1)) ? '0 : head + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
            if (wr.wr_ack)
                hi_half <= !hi_half;
        end
    end

    // ring accepts only from a non-empty store and only while not full
    a_no_empty_pop: assert property (@(posedge BUS_CLK) disable iff (RST)
        wr.wr_ack |-> !st_empty && !wr.wr_full);

endmodule
